/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f
	@out=$$(./obj_dir/Vtb_top +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

lint:
	verilator --lint-only -Wall --top-module cpu_core \
		hdl/bus_pkg.sv hdl/cpu_pkg.sv hdl/regfile.sv hdl/instr_fetch.sv \
		hdl/decode_and_issue.sv hdl/instr_exec.sv hdl/cpu_core.sv

clean:
	rm -rf obj_dir

/* hdl/bus_pkg.sv */
package bus_pkg;

	// instruction bus uses word addresses
	// one request returns two consecutive words, lower address in rdata[0]
	typedef struct packed {
		logic        read;
		logic [31:0] addr;
	} ibus_req_t;

	typedef struct packed {
		logic             valid;
		logic [1:0][31:0] rdata;
	} ibus_resp_t;

	// data bus carries stores only
	// the stall level comes back as a separate input
	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} dbus_req_t;

endpackage

/* hdl/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core #(
	parameter int ISSUE_NUM  = 2,
	parameter int REG_NUM    = 32,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	output bus_pkg::ibus_req_t  ibus_req,
	input  bus_pkg::ibus_resp_t ibus_resp,
	output bus_pkg::dbus_req_t  dbus_req,
	input  logic                dbus_stall
);
	import cpu_pkg::*;

	localparam int ACK_W = $clog2(ISSUE_NUM + 1);

	logic             stall_mm;
	logic [ACK_W-1:0] issue_num;
	logic [ACK_W-1:0] fetch_ack;

	logic      [ISSUE_NUM-1:0]   reg_we;
	reg_addr_t [ISSUE_NUM-1:0]   reg_waddr;
	uint32_t   [ISSUE_NUM-1:0]   reg_wdata;
	reg_addr_t [2*ISSUE_NUM-1:0] reg_raddr;
	uint32_t   [2*ISSUE_NUM-1:0] reg_rdata;

	fetch_entry_t     [ISSUE_NUM-1:0] fetch_entry;
	pipeline_decode_t [ISSUE_NUM-1:0] pipeline_decode, pipeline_decode_d;
	pipeline_exec_t   [ISSUE_NUM-1:0] pipeline_exec, pipeline_exec_d;
	pipeline_memwb_t  [ISSUE_NUM-1:0] pipeline_mem, pipeline_wb;

	regfile #(
		.REG_NUM     ( REG_NUM       ),
		.DATA_WIDTH  ( 32            ),
		.WRITE_PORTS ( ISSUE_NUM     ),
		.READ_PORTS  ( 2 * ISSUE_NUM ),
		.ZERO_KEEP   ( 1             )
	) u_regfile (
		.clk,
		.rst_n,
		.we    ( reg_we    ),
		.waddr ( reg_waddr ),
		.wdata ( reg_wdata ),
		.raddr ( reg_raddr ),
		.rdata ( reg_rdata )
	);

	instr_fetch #(
		.ISSUE_NUM  ( ISSUE_NUM  ),
		.FIFO_DEPTH ( FIFO_DEPTH )
	) u_instr_fetch (
		.clk,
		.rst_n,
		.stall       ( stall_mm    ),
		.ibus_req,
		.ibus_resp,
		.fetch_ack   ( fetch_ack   ),
		.fetch_entry ( fetch_entry )
	);

	decode_and_issue #(
		.ISSUE_NUM ( ISSUE_NUM )
	) u_decode_and_issue (
		.fetch_entry,
		.fetch_ack     ( issue_num       ),
		.pipeline_exec,
		.pipeline_mem  ( pipeline_exec_d ),
		.pipeline_wb,
		.reg_raddr,
		.reg_rdata,
		.pipeline_decode
	);

	// no pops while ID is frozen
	assign fetch_ack = stall_mm ? '0 : issue_num;

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_exec
		instr_exec u_instr_exec (
			.data   ( pipeline_decode_d[i] ),
			.result ( pipeline_exec[i]     )
		);
	end

	// ID/EX and EX/MEM hold while a store waits on the bus
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pipeline_decode_d <= '0;
			pipeline_exec_d   <= '0;
		end else if (!stall_mm) begin
			pipeline_decode_d <= pipeline_decode;
			pipeline_exec_d   <= pipeline_exec;
		end
	end

	// at most one slot carries a store
	always_comb begin
		dbus_req = '0;
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (pipeline_exec_d[i].valid && pipeline_exec_d[i].is_store) begin
				dbus_req.write = 1'b1;
				dbus_req.addr  = pipeline_exec_d[i].result;
				dbus_req.wdata = pipeline_exec_d[i].store_data;
			end
		end
	end

	assign stall_mm = dbus_stall && dbus_req.write;

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_mem
		assign pipeline_mem[i] = '{
			valid: pipeline_exec_d[i].valid,
			we:    pipeline_exec_d[i].we,
			rd:    pipeline_exec_d[i].rd,
			wdata: pipeline_exec_d[i].result
		};
	end

	// bubble into WB while MEM is held
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pipeline_wb <= '0;
		end else if (stall_mm) begin
			pipeline_wb <= '0;
		end else begin
			pipeline_wb <= pipeline_mem;
		end
	end

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_write_back
		assign reg_we[i]    = pipeline_wb[i].valid && pipeline_wb[i].we;
		assign reg_waddr[i] = pipeline_wb[i].rd;
		assign reg_wdata[i] = pipeline_wb[i].wdata;
	end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	// top nibble of the instruction
	// all-zero word decodes as nop
	typedef enum logic [3:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_or   = 4'd4,
		op_xor  = 4'd5,
		op_addi = 4'd6,
		op_sw   = 4'd7
	} opcode_t;

	// instruction field positions
	localparam int OP_LSB = 28;
	localparam int RD_LSB = 23;
	localparam int RS_LSB = 18;
	localparam int RT_LSB = 13;
	localparam int IMM_W  = 16;

	typedef struct packed {
		logic    valid;
		uint32_t instr;
	} fetch_entry_t;

	typedef struct packed {
		logic      valid;
		opcode_t   op;
		reg_addr_t rd;
		uint32_t   op1;
		uint32_t   op2;
		uint32_t   imm;
	} pipeline_decode_t;

	// result holds the store address for sw
	typedef struct packed {
		logic      valid;
		logic      we;
		logic      is_store;
		reg_addr_t rd;
		uint32_t   result;
		uint32_t   store_data;
	} pipeline_exec_t;

	typedef struct packed {
		logic      valid;
		logic      we;
		reg_addr_t rd;
		uint32_t   wdata;
	} pipeline_memwb_t;

endpackage

/* hdl/decode_and_issue.sv */
`timescale 1ns/1ns

module decode_and_issue #(
	parameter int ISSUE_NUM = 2
) (
	input  cpu_pkg::fetch_entry_t     [ISSUE_NUM-1:0]   fetch_entry,
	output logic [$clog2(ISSUE_NUM+1)-1:0]              fetch_ack,
	input  cpu_pkg::pipeline_exec_t   [ISSUE_NUM-1:0]   pipeline_exec,
	input  cpu_pkg::pipeline_exec_t   [ISSUE_NUM-1:0]   pipeline_mem,
	input  cpu_pkg::pipeline_memwb_t  [ISSUE_NUM-1:0]   pipeline_wb,
	output cpu_pkg::reg_addr_t        [2*ISSUE_NUM-1:0] reg_raddr,
	input  cpu_pkg::uint32_t          [2*ISSUE_NUM-1:0] reg_rdata,
	output cpu_pkg::pipeline_decode_t [ISSUE_NUM-1:0]   pipeline_decode
);
	import cpu_pkg::*;

	opcode_t   [ISSUE_NUM-1:0] op;
	reg_addr_t [ISSUE_NUM-1:0] rd;
	reg_addr_t [ISSUE_NUM-1:0] rs;
	reg_addr_t [ISSUE_NUM-1:0] rt;
	uint32_t   [ISSUE_NUM-1:0] imm;
	uint32_t   [ISSUE_NUM-1:0] op1;
	uint32_t   [ISSUE_NUM-1:0] op2;
	logic      [ISSUE_NUM-1:0] writes_rd;
	logic      [ISSUE_NUM-1:0] reads_rs;
	logic      [ISSUE_NUM-1:0] reads_rt;
	logic      [ISSUE_NUM-1:0] is_store;
	logic                      dual;

	// oldest source first so younger matches overwrite
	function automatic uint32_t forward_operand(input reg_addr_t addr, input uint32_t rf_value);
		uint32_t value;
		value = rf_value;
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (pipeline_wb[i].valid && pipeline_wb[i].we && pipeline_wb[i].rd == addr) begin
				value = pipeline_wb[i].wdata;
			end
		end
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (pipeline_mem[i].valid && pipeline_mem[i].we && pipeline_mem[i].rd == addr) begin
				value = pipeline_mem[i].result;
			end
		end
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (pipeline_exec[i].valid && pipeline_exec[i].we && pipeline_exec[i].rd == addr) begin
				value = pipeline_exec[i].result;
			end
		end
		if (addr == '0) begin
			value = '0;
		end
		return value;
	endfunction

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			op1[i] = forward_operand(rs[i], reg_rdata[2*i]);
			op2[i] = forward_operand(rt[i], reg_rdata[2*i+1]);
		end
	end

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_decode
		uint32_t word;

		assign word = fetch_entry[i].instr;
		// unused opcode values fall back to nop
		assign op[i] = (word[OP_LSB +: 4] <= 4'(op_sw)) ? opcode_t'(word[OP_LSB +: 4]) : op_nop;
		assign rd[i]  = word[RD_LSB +: $bits(reg_addr_t)];
		assign rs[i]  = word[RS_LSB +: $bits(reg_addr_t)];
		assign rt[i]  = word[RT_LSB +: $bits(reg_addr_t)];
		assign imm[i] = {{(32 - IMM_W){word[IMM_W-1]}}, word[IMM_W-1:0]};

		assign writes_rd[i] = op[i] != op_nop && op[i] != op_sw;
		assign reads_rs[i]  = op[i] != op_nop;
		assign reads_rt[i]  = op[i] != op_nop && op[i] != op_addi;
		assign is_store[i]  = op[i] == op_sw;

		assign reg_raddr[2*i]   = rs[i];
		assign reg_raddr[2*i+1] = rt[i];

		assign pipeline_decode[i] = '{
			valid: fetch_entry[i].valid && (i < fetch_ack),
			op:    op[i],
			rd:    rd[i],
			op1:   op1[i],
			op2:   op2[i],
			imm:   imm[i]
		};
	end

	always_comb begin
		dual = fetch_entry[1].valid;
		// slot 1 depends on slot 0
		if (writes_rd[0] && rd[0] != '0) begin
			if ((reads_rs[1] && rs[1] == rd[0]) || (reads_rt[1] && rt[1] == rd[0])) begin
				dual = 1'b0;
			end
		end
		// one store per cycle on the data bus
		if (is_store[0] && is_store[1]) begin
			dual = 1'b0;
		end
		if (!fetch_entry[0].valid) begin
			fetch_ack = '0;
		end else if (dual) begin
			fetch_ack = 2'd2;
		end else begin
			fetch_ack = 2'd1;
		end
	end

endmodule

/* hdl/instr_exec.sv */
`timescale 1ns/1ns

module instr_exec (
	input  cpu_pkg::pipeline_decode_t data,
	output cpu_pkg::pipeline_exec_t   result
);
	import cpu_pkg::*;

	uint32_t alu_out;
	logic    writes_rd;

	always_comb begin
		case (data.op)
			op_add:  alu_out = data.op1 + data.op2;
			op_sub:  alu_out = data.op1 - data.op2;
			op_and:  alu_out = data.op1 & data.op2;
			op_or:   alu_out = data.op1 | data.op2;
			op_xor:  alu_out = data.op1 ^ data.op2;
			// store address for sw
			op_addi, op_sw: alu_out = data.op1 + data.imm;
			default: alu_out = '0;
		endcase
	end

	assign writes_rd = data.op != op_nop && data.op != op_sw && data.rd != '0;

	assign result = '{
		valid:      data.valid,
		we:         data.valid && writes_rd,
		is_store:   data.valid && data.op == op_sw,
		rd:         data.rd,
		result:     alu_out,
		store_data: data.op2
	};

endmodule

/* hdl/instr_fetch.sv */
`timescale 1ns/1ns

module instr_fetch #(
	parameter int ISSUE_NUM  = 2,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  stall,
	output bus_pkg::ibus_req_t                    ibus_req,
	input  bus_pkg::ibus_resp_t                   ibus_resp,
	input  logic [$clog2(ISSUE_NUM+1)-1:0]        fetch_ack,
	output cpu_pkg::fetch_entry_t [ISSUE_NUM-1:0] fetch_entry
);
	import cpu_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	uint32_t                   pc;
	logic                      read_q;
	uint32_t [FIFO_DEPTH-1:0]  queue;
	logic    [PTR_W-1:0]       head;
	logic    [PTR_W-1:0]       tail;
	logic    [CNT_W-1:0]       count;
	logic    [CNT_W-1:0]       pop_num;
	logic    [CNT_W-1:0]       free;
	logic                      push;

	assign push    = read_q && ibus_resp.valid;
	assign pop_num = stall ? '0 : CNT_W'(fetch_ack);
	assign free    = CNT_W'(FIFO_DEPTH) - count;

	assign ibus_req.read = read_q;
	assign ibus_req.addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc     <= '0;
			read_q <= 1'b0;
			head   <= '0;
			tail   <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				read_q <= 1'b0;
				pc     <= pc + 32'd2;
				tail   <= tail + PTR_W'(2);
			end else if (!read_q && free >= CNT_W'(2)) begin
				// room for a whole pair before asking
				read_q <= 1'b1;
			end
			head  <= head + PTR_W'(pop_num);
			count <= count + (push ? CNT_W'(2) : '0) - pop_num;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			queue[tail]             <= ibus_resp.rdata[0];
			queue[tail + PTR_W'(1)] <= ibus_resp.rdata[1];
		end
	end

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_entry
		assign fetch_entry[i].valid = count > CNT_W'(i);
		assign fetch_entry[i].instr = queue[head + PTR_W'(i)];
	end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ns

module regfile #(
	parameter int REG_NUM     = 32,
	parameter int DATA_WIDTH  = 32,
	parameter int WRITE_PORTS = 2,
	parameter int READ_PORTS  = 4,
	parameter bit ZERO_KEEP   = 1
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic               [WRITE_PORTS-1:0] we,
	input  cpu_pkg::reg_addr_t [WRITE_PORTS-1:0] waddr,
	input  cpu_pkg::uint32_t   [WRITE_PORTS-1:0] wdata,
	input  cpu_pkg::reg_addr_t [READ_PORTS-1:0]  raddr,
	output cpu_pkg::uint32_t   [READ_PORTS-1:0]  rdata
);

	logic [REG_NUM-1:0][DATA_WIDTH-1:0] regs;

	// later port overrides an earlier one on the same register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '0;
		end else begin
			for (int w = 0; w < WRITE_PORTS; w++) begin
				if (we[w]) begin
					regs[waddr[w]] <= wdata[w];
				end
			end
		end
	end

	for (genvar r = 0; r < READ_PORTS; r++) begin : gen_read
		assign rdata[r] = (ZERO_KEEP && raddr[r] == '0) ? '0 : regs[raddr[r]];
	end

endmodule

/* tb.f */
hdl/bus_pkg.sv
hdl/cpu_pkg.sv
hdl/regfile.sv
hdl/instr_fetch.sv
hdl/decode_and_issue.sv
hdl/instr_exec.sv
hdl/cpu_core.sv
tests/tb_assert.sv
tests/tb_top.sv

/* tests/tb_assert.sv */
`timescale 1ns/1ns

module tb_assert (
	input logic               clk,
	input logic               rst_n,
	input bus_pkg::ibus_req_t ibus_req,
	input bus_pkg::dbus_req_t dbus_req,
	input logic               dbus_stall
);

	// both buses idle while held in reset
	reset_idle: assert property (@(posedge clk)
		!rst_n |-> !ibus_req.read && !dbus_req.write)
	else begin
		$error("error ibus_req.read %h dbus_req.write %h, expected 0 0 during reset",
			$sampled(ibus_req.read), $sampled(dbus_req.write));
		tb_top.assert_fails++;
	end

	// first cycle out of reset, fetch points at word 0
	reset_release: assert property (@(posedge clk)
		$rose(rst_n) |-> !ibus_req.read && !dbus_req.write && ibus_req.addr == '0)
	else begin
		$error("error ibus_req.addr %h, expected 00000000 after reset", $sampled(ibus_req.addr));
		tb_top.assert_fails++;
	end

	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dbus_req.write && dbus_stall |=> $stable(dbus_req))
	else begin
		$error("error dbus_req %h changed during a stall", $sampled(dbus_req));
		tb_top.assert_fails++;
	end

	extra_store: assert property (@(posedge clk) disable iff (!rst_n)
		dbus_req.write && !dbus_stall |-> tb_top.exp_valid)
	else begin
		$error("store completed with no store left in the expected stream");
		tb_top.assert_fails++;
	end

	store_value: assert property (@(posedge clk) disable iff (!rst_n)
		dbus_req.write && !dbus_stall && tb_top.exp_valid |->
			dbus_req.addr == tb_top.exp_addr && dbus_req.wdata == tb_top.exp_data)
	else begin
		$error("error dbus_req.addr %h dbus_req.wdata %h, expected %h %h",
			$sampled(dbus_req.addr), $sampled(dbus_req.wdata),
			$sampled(tb_top.exp_addr), $sampled(tb_top.exp_data));
		tb_top.assert_fails++;
	end

	no_unknown: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({ibus_req.read, ibus_req.addr, dbus_req.write, dbus_req.addr}))
	else begin
		$error("unknown value on a bus request signal");
		tb_top.assert_fails++;
	end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
	import cpu_pkg::*;
	import bus_pkg::*;

	localparam int TEST_NUM     = 6;
	localparam int TEST_CYCLES  = 400;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 20;
	localparam int RUN_LIMIT    = TEST_NUM * (TEST_CYCLES + RESET_CYCLES + DRAIN_CYCLES + 2);
	localparam int PROG_MAX     = 64;

	logic       clk;
	logic       rst_n;
	ibus_req_t  ibus_req;
	ibus_resp_t ibus_resp;
	dbus_req_t  dbus_req;
	logic       dbus_stall;

	uint32_t prog [PROG_MAX];
	int      prog_len;
	uint32_t exp_addr_q [$];
	uint32_t exp_data_q [$];
	logic    exp_valid;
	uint32_t exp_addr;
	uint32_t exp_data;
	int      assert_fails;
	int      fail_tests;
	int      cycle;
	logic    random_bus;
	int      resp_delay;
	int      resp_left;
	logic    resp_busy;

	cpu_core #(
		.ISSUE_NUM  ( 2  ),
		.REG_NUM    ( 32 ),
		.FIFO_DEPTH ( 4  )
	) u_dut (
		.clk,
		.rst_n,
		.ibus_req,
		.ibus_resp,
		.dbus_req,
		.dbus_stall
	);

	bind cpu_core tb_assert u_assert (
		.clk,
		.rst_n,
		.ibus_req,
		.dbus_req,
		.dbus_stall
	);

	always #4 clk = ~clk;

	function automatic uint32_t fetch_word(input uint32_t addr);
		if (addr < uint32_t'(prog_len)) begin
			return prog[addr[5:0]];
		end
		return '0;
	endfunction

	function automatic uint32_t alu_instr(input opcode_t op, input int rd, input int rs,
		input int rt);
		return {op, 5'(rd), 5'(rs), 5'(rt), 13'd0};
	endfunction

	function automatic uint32_t addi_instr(input int rd, input int rs, input int imm);
		return {op_addi, 5'(rd), 5'(rs), 2'b00, 16'(imm)};
	endfunction

	// offset shares bits 15:13 with rt
	function automatic uint32_t sw_instr(input int rs, input int rt, input int offset);
		return {op_sw, 5'd0, 5'(rs), 5'(rt), 13'(offset)};
	endfunction

	// instruction memory, one pair per read after resp_left cycles
	always @(negedge clk) begin
		ibus_resp.valid = 1'b0;
		if (!rst_n) begin
			resp_busy = 1'b0;
		end else if (ibus_req.read) begin
			if (!resp_busy) begin
				resp_busy = 1'b1;
				resp_left = random_bus ? int'($urandom_range(3, 1)) : resp_delay;
			end
			resp_left--;
			if (resp_left == 0) begin
				ibus_resp.valid    = 1'b1;
				ibus_resp.rdata[0] = fetch_word(ibus_req.addr);
				ibus_resp.rdata[1] = fetch_word(ibus_req.addr + 32'd1);
				resp_busy          = 1'b0;
			end
		end
		dbus_stall = random_bus ? 1'($urandom_range(1, 0)) : 1'b0;
	end

	task automatic update_head();
		exp_valid = exp_addr_q.size() > 0;
		exp_addr  = exp_valid ? exp_addr_q[0] : '0;
		exp_data  = exp_valid ? exp_data_q[0] : '0;
	endtask

	always @(posedge clk) begin
		cycle++;
		if (rst_n && dbus_req.write && !dbus_stall && exp_addr_q.size() > 0) begin
			void'(exp_addr_q.pop_front());
			void'(exp_data_q.pop_front());
			update_head();
		end
		if (cycle > RUN_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// sequential interpreter of the loaded program
	task automatic run_reference();
		uint32_t rf [32];
		uint32_t w;
		uint32_t a;
		uint32_t b;
		uint32_t imm;
		uint32_t v;
		logic    writes;
		exp_addr_q.delete();
		exp_data_q.delete();
		foreach (rf[r]) begin
			rf[r] = '0;
		end
		for (int p = 0; p < prog_len; p++) begin
			w      = prog[p];
			a      = rf[w[22:18]];
			b      = rf[w[17:13]];
			imm    = {{16{w[15]}}, w[15:0]};
			writes = 1'b1;
			v      = '0;
			case (opcode_t'(w[31:28]))
				op_add:  v = a + b;
				op_sub:  v = a - b;
				op_and:  v = a & b;
				op_or:   v = a | b;
				op_xor:  v = a ^ b;
				op_addi: v = a + imm;
				op_sw: begin
					exp_addr_q.push_back(a + imm);
					exp_data_q.push_back(b);
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && w[27:23] != 5'd0) begin
				rf[w[27:23]] = v;
			end
		end
		update_head();
	endtask

	task automatic emit(input uint32_t word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic emit_nops(input int n);
		for (int k = 0; k < n; k++) begin
			emit('0);
		end
	endtask

	task automatic load_program(input int num);
		opcode_t op;
		int      rd;
		int      rs;
		int      rt;
		prog_len = 0;
		foreach (prog[k]) begin
			prog[k] = '0;
		end
		case (num)
			2: begin
				emit(addi_instr(1, 0, 5));
				emit(addi_instr(2, 0, -3));
				emit(alu_instr(op_add, 3, 1, 2));
				emit(alu_instr(op_sub, 4, 1, 2));
				emit(alu_instr(op_and, 5, 1, 2));
				emit(alu_instr(op_or, 6, 1, 2));
				emit(alu_instr(op_xor, 7, 1, 2));
			end
			3: begin
				// distance 1, 2 and 3 pairs between producer and consumer
				emit(addi_instr(1, 0, 7));
				emit_nops(1);
				emit(alu_instr(op_add, 2, 1, 1));
				emit_nops(3);
				emit(alu_instr(op_add, 3, 2, 1));
				emit_nops(5);
				emit(alu_instr(op_add, 4, 3, 2));
				emit(alu_instr(op_sub, 5, 4, 3));
				emit(alu_instr(op_xor, 6, 5, 4));
				emit(alu_instr(op_or, 7, 6, 5));
			end
			4: begin
				emit(addi_instr(1, 0, 3));
				emit(alu_instr(op_add, 2, 1, 1));
				emit(addi_instr(3, 0, 9));
				emit(alu_instr(op_xor, 4, 2, 3));
				emit(sw_instr(0, 1, 8));
				emit(sw_instr(0, 2, 12));
				emit(addi_instr(1, 1, 1));
				emit(sw_instr(0, 1, 24));
			end
			5: begin
				for (int k = 0; k < 40; k++) begin
					op = opcode_t'(4'($urandom_range(7, 1)));
					rd = int'($urandom_range(7, 0));
					rs = int'($urandom_range(7, 0));
					rt = int'($urandom_range(7, 0));
					if (op == op_addi) begin
						emit(addi_instr(rd, rs, int'($urandom_range(255, 0)) - 128));
					end else if (op == op_sw) begin
						emit(sw_instr(0, rt, 4 * k));
					end else begin
						emit(alu_instr(op, rd, rs, rt));
					end
				end
			end
			6: begin
				emit(addi_instr(1, 0, 11));
				emit(addi_instr(0, 0, 55));
				emit(alu_instr(op_add, 0, 1, 1));
				emit(alu_instr(op_xor, 0, 1, 0));
				emit(sw_instr(0, 0, 64));
				emit(alu_instr(op_add, 2, 0, 1));
			end
			default: begin
			end
		endcase
		// every register stored at the end
		if (num != 1) begin
			for (int r = 0; r < 8; r++) begin
				emit(sw_instr(0, r, 4 * r));
			end
		end
	endtask

	task automatic run_test(input int num, input string name);
		int fails_before;
		int wait_cnt;
		fails_before = assert_fails;
		@(negedge clk);
		rst_n      = 1'b0;
		random_bus = num == 5;
		resp_delay = 1 + num % 3;
		load_program(num);
		run_reference();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n    = 1'b1;
		wait_cnt = 0;
		while (exp_addr_q.size() > 0 && wait_cnt < TEST_CYCLES) begin
			@(negedge clk);
			wait_cnt++;
		end
		// room for any stray store to show up
		repeat (DRAIN_CYCLES) @(negedge clk);
		if (exp_addr_q.size() > 0) begin
			$display("test %0d %s: failed, %0d expected stores missing", num, name,
				exp_addr_q.size());
			fail_tests++;
		end else if (assert_fails != fails_before) begin
			$display("test %0d %s: failed, %0d assertion errors", num, name,
				assert_fails - fails_before);
			fail_tests++;
		end else begin
			$display("test %0d %s: passed", num, name);
		end
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		ibus_resp    = '0;
		dbus_stall   = 1'b0;
		random_bus   = 1'b0;
		resp_delay   = 1;
		resp_left    = 0;
		resp_busy    = 1'b0;
		assert_fails = 0;
		fail_tests   = 0;
		cycle        = 0;
		prog_len     = 0;
		exp_valid    = 1'b0;
		exp_addr     = '0;
		exp_data     = '0;
		void'($urandom(32'h01ab169a));
		run_test(1, "reset");
		run_test(2, "alu ops");
		run_test(3, "forwarding");
		run_test(4, "single issue");
		run_test(5, "random stalls");
		run_test(6, "register zero");
		$display("tests run %0d, tests failed %0d, assertion errors %0d", TEST_NUM,
			fail_tests, assert_fails);
		if (fail_tests == 0 && assert_fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
